// ==== apu_cluster.f ====
common/apu_pkg.sv
common/apu_core_if.sv
common/apu_unit_if.sv
rtl/int_mult/int_mult_unit.sv
rtl/int_div/int_div_unit.sv
rtl/apu_splitter.sv
rtl/apu_arbiter.sv
rtl/apu_cluster.sv
testbench/apu_cluster_chk.sv
testbench/apu_cluster_tb.sv

// ==== common/apu_core_if.sv ====
// Request and result bundle for one unit type, all cores side by side.
// Requests come from the splitter, acks and results from the arbiter.
// Ack and valid are single-cycle pulses, one bit per core.

`timescale 1ns/1ps

interface apu_core_if import apu_pkg::*; ();

   // Core to arbiter
   core_mask_t req;
   op_t        op        [NB_CORES];
   word_t      operand_a [NB_CORES];
   word_t      operand_b [NB_CORES];

   // Arbiter to core
   core_mask_t ack;
   core_mask_t valid;
   word_t      result    [NB_CORES];

   modport splitter (
      output req, op, operand_a, operand_b,
      input  ack, valid, result
   );

   modport arbiter (
      input  req, op, operand_a, operand_b,
      output ack, valid, result
   );

endinterface

// ==== common/apu_pkg.sv ====
// Shared constants and types for the arithmetic cluster.
// NB_CORES must stay a power of two, since core indices wrap in TAG_W bits.
// Latencies are counted from the ack cycle to the result cycle.

package apu_pkg;

   //////////////////////////////
   // Cluster sizing
   //////////////////////////////

   localparam int NB_CORES = 4;
   localparam int NB_TYPES = 2;
   localparam int TAG_W    = $clog2(NB_CORES);

   // Unit latencies in cycles
   localparam int MULT_LATENCY = 3;
   localparam int DIV_LATENCY  = 34;

   //////////////////////////////
   // Data types
   //////////////////////////////

   typedef logic [31:0]         word_t;
   typedef logic [TAG_W-1:0]    core_tag_t;
   typedef logic [NB_CORES-1:0] core_mask_t;

   // Raw opcode field, meaning depends on unit type
   typedef logic [1:0] op_t;

   typedef enum logic [$clog2(NB_TYPES)-1:0] {
      APU_MULT,
      APU_DIV
   } apu_type_e;

   typedef enum logic [1:0] {
      MUL_LO,
      MUL_H,
      MUL_HSU,
      MUL_HU
   } mult_op_e;

   typedef enum logic [1:0] {
      DIV_S,
      DIV_U,
      REM_S,
      REM_U
   } div_op_e;

endpackage

// ==== common/apu_unit_if.sv ====
// Job and result bundle between an arbiter and its execution unit.
// A job moves on a rising edge with en and ready both high.
// Results are one-cycle pulses and are never stalled.

`timescale 1ns/1ps

interface apu_unit_if import apu_pkg::*; ();

   // Job issue
   logic      en;
   op_t       op;
   word_t     operand_a;
   word_t     operand_b;
   core_tag_t tag;

   // Unit status and result
   logic      ready;
   logic      res_valid;
   core_tag_t res_tag;
   word_t     result;

   modport arbiter (
      output en, op, operand_a, operand_b, tag,
      input  ready, res_valid, res_tag, result
   );

   modport unit (
      input  en, op, operand_a, operand_b, tag,
      output ready, res_valid, res_tag, result
   );

endinterface

// ==== rtl/apu_arbiter.sv ====
// Round-robin arbiter in front of one execution unit.
// Grant is combinational from req and ready, so ack and en share a cycle.
// Results are routed back by tag with no buffering.

`timescale 1ns/1ps

module apu_arbiter import apu_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   apu_core_if.arbiter cores,
   apu_unit_if.arbiter unit
);

   core_tag_t ptr_q;
   core_tag_t gnt_idx;
   logic      found;

   //////////////////////////////
   // Grant selection
   //////////////////////////////

   // First requester at or after the pointer
   always_comb begin
      core_tag_t idx;
      found   = 1'b0;
      gnt_idx = ptr_q;
      for (int k = 0; k < NB_CORES; k++) begin
         idx = core_tag_t'(ptr_q + k);
         if (!found && cores.req[idx]) begin
            found   = 1'b1;
            gnt_idx = idx;
         end
      end
   end

   // Pointer skips past the core that won
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ptr_q <= '0;
      end else if (unit.en) begin
         ptr_q <= core_tag_t'(gnt_idx + 1'b1);
      end
   end

   //////////////////////////////
   // Job issue
   //////////////////////////////

   assign unit.en        = unit.ready & found;
   assign unit.tag       = gnt_idx;
   assign unit.op        = cores.op[gnt_idx];
   assign unit.operand_a = cores.operand_a[gnt_idx];
   assign unit.operand_b = cores.operand_b[gnt_idx];

   assign cores.ack = unit.en ? (core_mask_t'(1) << gnt_idx) : '0;

   //////////////////////////////
   // Result return
   //////////////////////////////

   assign cores.valid = unit.res_valid ? (core_mask_t'(1) << unit.res_tag) : '0;

   // Only the owning core's slot carries the word
   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         if (cores.valid[i]) begin
            cores.result[i] = unit.result;
         end else begin
            cores.result[i] = '0;
         end
      end
   end

endmodule

// ==== rtl/apu_cluster.sv ====
// Shared integer multiplier and divider for NB_CORES cores.
// One outstanding request per core. Results are pulses with no back-pressure,
// so a core must take valid_o and result_o in the cycle they appear.

`timescale 1ns/1ps

module apu_cluster import apu_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  core_mask_t req_i,
   input  apu_type_e  type_i      [NB_CORES],
   input  op_t        op_i        [NB_CORES],
   input  word_t      operand_a_i [NB_CORES],
   input  word_t      operand_b_i [NB_CORES],
   output core_mask_t ack_o,
   output core_mask_t valid_o,
   output word_t      result_o    [NB_CORES]
);

   apu_core_if mult_core ();
   apu_core_if div_core ();
   apu_unit_if mult_unit ();
   apu_unit_if div_unit ();

   //////////////////////////////
   // Core side routing
   //////////////////////////////

   apu_splitter apu_splitter_i (
      .req_i       (req_i),
      .type_i      (type_i),
      .op_i        (op_i),
      .operand_a_i (operand_a_i),
      .operand_b_i (operand_b_i),
      .ack_o       (ack_o),
      .valid_o     (valid_o),
      .result_o    (result_o),
      .mult_port   (mult_core),
      .div_port    (div_core)
   );

   //////////////////////////////
   // Multiplier path
   //////////////////////////////

   apu_arbiter mult_arbiter_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cores (mult_core),
      .unit  (mult_unit)
   );

   int_mult_unit int_mult_unit_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .unit  (mult_unit)
   );

   //////////////////////////////
   // Divider path
   //////////////////////////////

   apu_arbiter div_arbiter_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cores (div_core),
      .unit  (div_unit)
   );

   int_div_unit int_div_unit_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .unit  (div_unit)
   );

endmodule

// ==== rtl/apu_splitter.sv ====
// Steers each core request to the arbiter of its unit type.
// Purely combinational. Assumes a core never has results from both
// unit types in the same cycle.

`timescale 1ns/1ps

module apu_splitter import apu_pkg::*; (
   input  core_mask_t          req_i,
   input  apu_type_e           type_i      [NB_CORES],
   input  op_t                 op_i        [NB_CORES],
   input  word_t               operand_a_i [NB_CORES],
   input  word_t               operand_b_i [NB_CORES],
   output core_mask_t          ack_o,
   output core_mask_t          valid_o,
   output word_t               result_o    [NB_CORES],
   apu_core_if.splitter        mult_port,
   apu_core_if.splitter        div_port
);

   // Opcode and operands go to both arbiters, only req is steered
   assign mult_port.op        = op_i;
   assign mult_port.operand_a = operand_a_i;
   assign mult_port.operand_b = operand_b_i;

   assign div_port.op         = op_i;
   assign div_port.operand_a  = operand_a_i;
   assign div_port.operand_b  = operand_b_i;

   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         mult_port.req[i] = req_i[i] && (type_i[i] == APU_MULT);
         div_port.req[i]  = req_i[i] && (type_i[i] == APU_DIV);
      end
   end

   //////////////////////////////
   // Merge of returns
   //////////////////////////////

   assign ack_o   = mult_port.ack | div_port.ack;
   assign valid_o = mult_port.valid | div_port.valid;

   // Result from whichever type flags valid for this core
   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         if (mult_port.valid[i]) begin
            result_o[i] = mult_port.result[i];
         end else begin
            result_o[i] = div_port.result[i];
         end
      end
   end

endmodule

// ==== rtl/int_div/int_div_unit.sv ====
// Iterative radix-2 divider, quotient or remainder, one job at a time.
// Busy from acceptance until res_valid, which comes DIV_LATENCY cycles later.
// Divide by zero returns all ones or the dividend, as RISC-V does.

`timescale 1ns/1ps

module int_div_unit import apu_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   apu_unit_if.unit  unit
);

   typedef enum logic [1:0] {
      IDLE,
      CALC,
      DONE
   } div_state_e;

   div_state_e  state_q;
   logic [4:0]  cnt_q;
   logic        res_valid_q;

   word_t       quo_q;
   word_t       rem_q;
   word_t       dvs_q;
   logic        is_rem_q;
   logic        neg_q_q;
   logic        neg_r_q;
   core_tag_t   tag_q;
   word_t       result_q;
   core_tag_t   res_tag_q;

   div_op_e     op_in;
   logic        sgn_in;
   logic        sign_a;
   logic        sign_b;
   word_t       mag_a;
   word_t       mag_b;
   logic [32:0] rem_sh;
   logic [32:0] diff;
   word_t       quo_fin;
   word_t       rem_fin;

   //////////////////////////////
   // Operand decode
   //////////////////////////////

   assign op_in  = div_op_e'(unit.op);
   assign sgn_in = (op_in == DIV_S) || (op_in == REM_S);
   assign sign_a = sgn_in & unit.operand_a[31];
   assign sign_b = sgn_in & unit.operand_b[31];
   assign mag_a  = sign_a ? -unit.operand_a : unit.operand_a;
   assign mag_b  = sign_b ? -unit.operand_b : unit.operand_b;

   // One restoring step, dividend bits shift out of quo_q
   assign rem_sh = {rem_q, quo_q[31]};
   assign diff   = rem_sh - {1'b0, dvs_q};

   // MIN / -1 falls out as 0x80000000 with remainder 0
   assign quo_fin = neg_q_q ? -quo_q : quo_q;
   assign rem_fin = neg_r_q ? -rem_q : rem_q;

   //////////////////////////////
   // Control FSM
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= IDLE;
         cnt_q       <= '0;
         res_valid_q <= 1'b0;
      end else begin
         res_valid_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (unit.en) begin
                  state_q <= CALC;
                  cnt_q   <= '0;
               end
            end
            CALC: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == 5'(DIV_LATENCY - 3)) begin
                  state_q <= DONE;
               end
            end
            DONE: begin
               res_valid_q <= 1'b1;
               state_q     <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Datapath
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      case (state_q)
         IDLE: begin
            if (unit.en) begin
               quo_q    <= mag_a;
               rem_q    <= '0;
               dvs_q    <= mag_b;
               is_rem_q <= (op_in == REM_S) || (op_in == REM_U);
               // Zero divisor keeps the quotient at all ones
               neg_q_q  <= (sign_a ^ sign_b) && (|unit.operand_b);
               neg_r_q  <= sign_a;
               tag_q    <= unit.tag;
            end
         end
         CALC: begin
            if (!diff[32]) begin
               rem_q <= diff[31:0];
               quo_q <= {quo_q[30:0], 1'b1};
            end else begin
               rem_q <= rem_sh[31:0];
               quo_q <= {quo_q[30:0], 1'b0};
            end
         end
         DONE: begin
            result_q  <= is_rem_q ? rem_fin : quo_fin;
            res_tag_q <= tag_q;
         end
         default: ;
      endcase
   end

   assign unit.ready     = (state_q == IDLE);
   assign unit.res_valid = res_valid_q;
   assign unit.res_tag   = res_tag_q;
   assign unit.result    = result_q;

endmodule

// ==== rtl/int_mult/int_mult_unit.sv ====
// Three-stage 32x32 integer multiplier, one job per cycle.
// Always ready. Result MULT_LATENCY cycles after acceptance.

`timescale 1ns/1ps

module int_mult_unit import apu_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   apu_unit_if.unit  unit
);

   mult_op_e           op_in;
   logic               sgn_a;
   logic               sgn_b;

   logic               valid_s1, valid_s2, valid_s3;
   core_tag_t          tag_s1, tag_s2, tag_s3;
   logic               hi_s1, hi_s2;
   logic signed [32:0] a_s1, b_s1;
   logic [63:0]        prod_s2;
   word_t              res_s3;

   // Signedness per operand, low word does not care
   assign op_in = mult_op_e'(unit.op);
   assign sgn_a = (op_in == MUL_H) || (op_in == MUL_HSU);
   assign sgn_b = (op_in == MUL_H);

   assign unit.ready = 1'b1;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_s1 <= 1'b0;
         valid_s2 <= 1'b0;
         valid_s3 <= 1'b0;
      end else begin
         valid_s1 <= unit.en;
         valid_s2 <= valid_s1;
         valid_s3 <= valid_s2;
      end
   end

   always_ff @(posedge clk_i) begin
      // Stage 1: extended operands
      a_s1   <= {sgn_a & unit.operand_a[31], unit.operand_a};
      b_s1   <= {sgn_b & unit.operand_b[31], unit.operand_b};
      hi_s1  <= (op_in != MUL_LO);
      tag_s1 <= unit.tag;
      // Stage 2: full product
      prod_s2 <= 64'(a_s1) * 64'(b_s1);
      hi_s2   <= hi_s1;
      tag_s2  <= tag_s1;
      // Stage 3: word select
      res_s3 <= hi_s2 ? prod_s2[63:32] : prod_s2[31:0];
      tag_s3 <= tag_s2;
   end

   assign unit.res_valid = valid_s3;
   assign unit.res_tag   = tag_s3;
   assign unit.result    = res_s3;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module apu_cluster_tb -f apu_cluster.f \
   || { echo "Verilator build failed"; exit 1; }

# Let assertion errors reach the testbench summary instead of stopping early
./obj_dir/Vapu_cluster_tb +verilator+error+limit+1000 | tee /dev/stderr \
   | grep -x "TEST PASSED" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== testbench/apu_cluster_chk.sv ====
// Protocol checks for one arbiter and the unit behind it.
// Bound into every apu_arbiter, sampled on the rising clock edge.
// Nothing is checked while rst_i is high.

`timescale 1ns/1ps

module apu_cluster_chk import apu_pkg::*; (
   input logic       clk_i,
   input logic       rst_i,
   input core_mask_t ack_i,
   input logic       en_i,
   input logic       ready_i
);

   int fail_cnt;

   // One grant per cycle at most
   one_ack_a: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ack_i))
      else begin
         fail_cnt++;
         $error("more than one core acked by the same arbiter in one cycle");
      end

   no_en_busy_a: assert property (@(posedge clk_i) disable iff (rst_i) !(en_i && !ready_i))
      else begin
         fail_cnt++;
         $error("job issued while the unit was not ready");
      end

endmodule

bind apu_arbiter apu_cluster_chk chk_i (
   .clk_i   (clk_i),
   .rst_i   (rst_i),
   .ack_i   (cores.ack),
   .en_i    (unit.en),
   .ready_i (unit.ready)
);

// ==== testbench/apu_cluster_tb.sv ====
// Testbench for the shared multiplier and divider cluster.
// Each core runs random jobs, then all cores hit the divider at once,
// then three multiplier jobs overlap a divide. Acks are checked against
// a round-robin model every cycle, results against a reference model.

`timescale 1ns/1ps

module apu_cluster_tb import apu_pkg::*; ();

   localparam int N_JOBS = 200;
   localparam int WATCHDOG_CYCLES =
      (N_JOBS + 2) * (DIV_LATENCY + NB_CORES * DIV_LATENCY) + 20;

   logic       clk_i = 1'b0;
   logic       rst_i;
   core_mask_t req_i;
   apu_type_e  type_i      [NB_CORES];
   op_t        op_i        [NB_CORES];
   word_t      operand_a_i [NB_CORES];
   word_t      operand_b_i [NB_CORES];
   core_mask_t ack_o;
   core_mask_t valid_o;
   word_t      result_o    [NB_CORES];

   integer     seed;
   int         cycle;
   int         err_cnt;
   int         chk_cnt;
   bit         stim_ready;
   core_mask_t rnd_done;
   core_mask_t rr_done;
   core_mask_t all_done;

   // Pre-drawn stimulus per core and job
   apu_type_e  job_type [NB_CORES][N_JOBS];
   op_t        job_op   [NB_CORES][N_JOBS];
   word_t      job_a    [NB_CORES][N_JOBS];
   word_t      job_b    [NB_CORES][N_JOBS];
   int         job_gap  [NB_CORES][N_JOBS];

   // Round-robin model state
   int         mult_ptr;
   int         div_ptr;
   int         div_free;
   int         mi;
   int         di;
   core_mask_t mreq;
   core_mask_t dreq;
   core_mask_t exp_ack;

   apu_cluster apu_cluster_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .type_i      (type_i),
      .op_i        (op_i),
      .operand_a_i (operand_a_i),
      .operand_b_i (operand_b_i),
      .ack_o       (ack_o),
      .valid_o     (valid_o),
      .result_o    (result_o)
   );

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle <= cycle + 1;
   end

   //////////////////////////////
   // Checking helpers
   //////////////////////////////

   task automatic compare(input word_t got, input word_t exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic print_summary();
      int asrt_fail;
      asrt_fail = apu_cluster_i.mult_arbiter_i.chk_i.fail_cnt +
                  apu_cluster_i.div_arbiter_i.chk_i.fail_cnt;
      $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
               chk_cnt, err_cnt, asrt_fail);
   endtask

   // Reference results, RISC-V style corner cases
   function automatic word_t model_result(apu_type_e t, op_t op, word_t a, word_t b);
      logic [63:0] ea;
      logic [63:0] eb;
      logic [63:0] prod;
      int          sa;
      int          sb;
      if (t == APU_MULT) begin
         ea   = {{32{a[31] && (op == MUL_H || op == MUL_HSU)}}, a};
         eb   = {{32{b[31] && (op == MUL_H)}}, b};
         prod = ea * eb;
         return (op == MUL_LO) ? prod[31:0] : prod[63:32];
      end
      sa = a;
      sb = b;
      if (b == 32'h0) begin
         return (op == DIV_S || op == DIV_U) ? 32'hFFFF_FFFF : a;
      end
      if ((op == DIV_S || op == REM_S) && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
         return (op == DIV_S) ? a : 32'h0;
      end
      case (div_op_e'(op))
         DIV_S:   return word_t'(sa / sb);
         DIV_U:   return a / b;
         REM_S:   return word_t'(sa % sb);
         default: return a % b;
      endcase
   endfunction

   // Biased toward zero, all ones and the most negative value
   function automatic word_t draw_operand();
      case ($unsigned($random(seed)) % 6)
         0:       return 32'h0;
         1:       return 32'hFFFF_FFFF;
         2:       return 32'h8000_0000;
         3:       return word_t'($unsigned($random(seed)) % 16);
         default: return word_t'($random(seed));
      endcase
   endfunction

   function automatic int rr_next(core_mask_t mask, int ptr);
      int idx;
      for (int k = 0; k < NB_CORES; k++) begin
         idx = (ptr + k) % NB_CORES;
         if (mask[core_tag_t'(idx)]) begin
            return idx;
         end
      end
      return -1;
   endfunction

   //////////////////////////////
   // Round-robin ack model
   //////////////////////////////

   // Sampled mid-cycle where inputs and acks are settled
   always @(negedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < NB_CORES; i++) begin
            mreq[i] = req_i[i] && (type_i[i] == APU_MULT);
            dreq[i] = req_i[i] && (type_i[i] == APU_DIV);
         end
         mi = rr_next(mreq, mult_ptr);
         di = (cycle >= div_free) ? rr_next(dreq, div_ptr) : -1;
         exp_ack = '0;
         if (mi >= 0) begin
            exp_ack  = exp_ack | (core_mask_t'(1) << mi);
            mult_ptr = (mi + 1) % NB_CORES;
         end
         if (di >= 0) begin
            exp_ack  = exp_ack | (core_mask_t'(1) << di);
            div_ptr  = (di + 1) % NB_CORES;
            div_free = cycle + DIV_LATENCY;
         end
         compare(word_t'(ack_o), word_t'(exp_ack), "ack mask against round-robin model");
      end
   end

   //////////////////////////////
   // Per-core stimulus
   //////////////////////////////

   for (genvar c = 0; c < NB_CORES; c++) begin : core_g
      logic      req_q;
      apu_type_e type_q;
      op_t       op_q;
      word_t     a_q;
      word_t     b_q;
      int        phase_q;

      assign req_i[c]       = req_q;
      assign type_i[c]      = type_q;
      assign op_i[c]        = op_q;
      assign operand_a_i[c] = a_q;
      assign operand_b_i[c] = b_q;
      assign rnd_done[c]    = (phase_q >= 1);
      assign rr_done[c]     = (phase_q >= 2);
      assign all_done[c]    = (phase_q >= 3);

      // One request, its ack, its result
      task automatic run_job(input apu_type_e t, input op_t op, input word_t a, input word_t b);
         int    ack_cyc;
         int    lat;
         word_t exp;
         exp = model_result(t, op, a, b);
         lat = (t == APU_MULT) ? MULT_LATENCY : DIV_LATENCY;
         @(posedge clk_i);
         req_q  <= 1'b1;
         type_q <= t;
         op_q   <= op;
         a_q    <= a;
         b_q    <= b;
         @(negedge clk_i);
         while (!ack_o[c]) begin
            compare(word_t'(valid_o[c]), 32'h0, $sformatf("core %0d valid before ack", c));
            @(negedge clk_i);
         end
         ack_cyc = cycle;
         @(posedge clk_i);
         req_q <= 1'b0;
         @(negedge clk_i);
         while (!valid_o[c]) begin
            compare(word_t'(ack_o[c]), 32'h0, $sformatf("core %0d second ack", c));
            @(negedge clk_i);
         end
         compare(word_t'(cycle - ack_cyc), word_t'(lat), $sformatf("core %0d latency", c));
         compare(result_o[c], exp,
                 $sformatf("core %0d type %0d op %0d a %h b %h", c, t, op, a, b));
      endtask

      initial begin
         req_q   <= 1'b0;
         type_q  <= APU_MULT;
         op_q    <= '0;
         a_q     <= '0;
         b_q     <= '0;
         phase_q = 0;
         wait (stim_ready);
         for (int n = 0; n < N_JOBS; n++) begin
            run_job(job_type[c][n], job_op[c][n], job_a[c][n], job_b[c][n]);
            repeat (job_gap[c][n]) begin
               @(negedge clk_i);
               compare(word_t'(ack_o[c] | valid_o[c]), 32'h0,
                       $sformatf("core %0d pulse while idle", c));
            end
         end
         phase_q = 1;

         // All cores on the divider in the same cycle, overflow and zero divisors
         wait (&rnd_done);
         run_job(APU_DIV, op_t'(c), 32'h8000_0000, (c % 2 == 0) ? 32'hFFFF_FFFF : 32'h0);
         phase_q = 2;

         // Core 0 holds the divider while the others share the multiplier
         wait (&rr_done);
         if (c == 0) begin
            run_job(APU_DIV, op_t'(DIV_U), 32'd1000, 32'd7);
         end else begin
            @(posedge clk_i);
            run_job(APU_MULT, op_t'(c), 32'hFFFF_FFF0 + c, 32'h8000_0003);
         end
         phase_q = 3;
      end
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      rst_i <= 1'b1;
      seed  = 82456;
      for (int c = 0; c < NB_CORES; c++) begin
         for (int n = 0; n < N_JOBS; n++) begin
            job_type[c][n] = apu_type_e'(1'($random(seed)));
            job_op[c][n]   = op_t'($random(seed));
            job_a[c][n]    = draw_operand();
            job_b[c][n]    = draw_operand();
            job_gap[c][n]  = $unsigned($random(seed)) % 4;
         end
      end
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      stim_ready = 1'b1;
      wait (&all_done);
      repeat (4) @(posedge clk_i);
      print_summary();
      if (err_cnt == 0 &&
          apu_cluster_i.mult_arbiter_i.chk_i.fail_cnt == 0 &&
          apu_cluster_i.div_arbiter_i.chk_i.fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Worst case every job waits behind all other cores on the divider
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("Timeout: jobs still pending after %0d cycles", WATCHDOG_CYCLES);
      print_summary();
      $display("TEST FAILED");
      $finish;
   end

endmodule
